// ==== hw/elevator_params.svh ====
// Elevator build constants

`ifndef ELEVATOR_PARAMS_SVH
`define ELEVATOR_PARAMS_SVH

////////////////////////////////////////
// Building size
////////////////////////////////////////

// Number of floors served
`define ELEV_NUM_FLOORS 11

// Bits needed to index one floor
`define ELEV_FLOOR_W 4

`endif

// ==== hw/elevator_pkg.sv ====
// Elevator design types

`default_nettype none

`include "elevator_params.svh"

package elevator_pkg;

    // Floor index, 0 is the ground floor
    typedef logic [`ELEV_FLOOR_W-1:0] floor_t;

    // One bit per floor for buttons and lamps
    typedef logic [`ELEV_NUM_FLOORS-1:0] floor_mask_t;

    // Travel direction as seen by the motion FSM
    typedef enum logic {
        DIR_DOWN = 1'b0,
        DIR_UP   = 1'b1
    } dir_e;

    // Scheduler holds its target while serving
    typedef enum logic {
        SCHED_IDLE    = 1'b0,
        SCHED_SERVING = 1'b1
    } sched_state_e;

endpackage

`default_nettype wire

// ==== hw/floor_logic_top.sv ====
// Floor request controller top

`default_nettype none
`timescale 1ns/1ps

module floor_logic_top (
    input  wire                            clock,
    input  wire                            reset_n,
    // Buttons, high while pressed
    input  wire elevator_pkg::floor_mask_t floor_call_buttons,
    input  wire elevator_pkg::floor_mask_t panel_buttons,
    input  wire                            door_open_btn,
    input  wire                            door_close_btn,
    input  wire                            emergency_btn,
    input  wire                            power_switch,
    // Status from the motion FSM
    input  wire elevator_pkg::floor_t      current_floor,
    input  wire                            elevator_moving,
    input  wire elevator_pkg::dir_e        elevator_direction,
    // Lamps
    output wire elevator_pkg::floor_mask_t call_button_lights,
    output wire elevator_pkg::floor_mask_t panel_button_lights,
    // Commands to the motion FSM
    output wire elevator_pkg::floor_t      elevator_floor_selector,
    output wire elevator_pkg::dir_e        direction_selector,
    output wire                            activate_elevator,
    output wire                            door_open_allowed,
    output wire                            door_close_allowed
);

    ////////////////////////////////////////
    // Request lamps
    ////////////////////////////////////////

    request_latch u_request_latch (
        .clock               (clock),
        .reset_n             (reset_n),
        .floor_call_buttons  (floor_call_buttons),
        .panel_buttons       (panel_buttons),
        .power_switch        (power_switch),
        .emergency_btn       (emergency_btn),
        .current_floor       (current_floor),
        .elevator_moving     (elevator_moving),
        .call_button_lights  (call_button_lights),
        .panel_button_lights (panel_button_lights)
    );

    ////////////////////////////////////////
    // Target selection
    ////////////////////////////////////////

    // The chosen target goes straight out as the floor selector
    floor_scheduler u_floor_scheduler (
        .clock               (clock),
        .reset_n             (reset_n),
        .call_button_lights  (call_button_lights),
        .panel_button_lights (panel_button_lights),
        .current_floor       (current_floor),
        .elevator_moving     (elevator_moving),
        .elevator_direction  (elevator_direction),
        .target_floor        (elevator_floor_selector)
    );

    ////////////////////////////////////////
    // Motion and door commands
    ////////////////////////////////////////

    motion_control u_motion_control (
        .clock              (clock),
        .reset_n            (reset_n),
        .target_floor       (elevator_floor_selector),
        .current_floor      (current_floor),
        .elevator_moving    (elevator_moving),
        .power_switch       (power_switch),
        .emergency_btn      (emergency_btn),
        .door_open_btn      (door_open_btn),
        .door_close_btn     (door_close_btn),
        .activate_elevator  (activate_elevator),
        .direction_selector (direction_selector),
        .door_open_allowed  (door_open_allowed),
        .door_close_allowed (door_close_allowed)
    );

endmodule

`default_nettype wire

// ==== hw/floor_scheduler.sv ====
// Next target floor selection

`default_nettype none
`timescale 1ns/1ps

`include "elevator_params.svh"

module floor_scheduler (
    input  wire                        clock,
    input  wire                        reset_n,
    input  wire elevator_pkg::floor_mask_t call_button_lights,
    input  wire elevator_pkg::floor_mask_t panel_button_lights,
    input  wire elevator_pkg::floor_t  current_floor,
    input  wire                        elevator_moving,
    input  wire elevator_pkg::dir_e    elevator_direction,
    output elevator_pkg::floor_t       target_floor
);
    import elevator_pkg::*;

    floor_mask_t  pending;
    sched_state_e state;
    logic         load_target;
    logic         up_found;
    floor_t       up_floor;
    logic         down_found;
    floor_t       down_floor;
    floor_t       target_next;

    // Hall calls and cab requests are served alike
    assign pending = call_button_lights | panel_button_lights;

    // New target only when idle with the car standing
    assign load_target = (state == SCHED_IDLE) && !elevator_moving;

    ////////////////////////////////////////
    // Nearest pending floor each way
    ////////////////////////////////////////

    // Scan from the top so the closest floor above wins
    always_comb begin
        up_found = 1'b0;
        up_floor = current_floor;
        for (int i = `ELEV_NUM_FLOORS - 1; i >= 0; i--) begin
            if (pending[i] && (i > int'(current_floor))) begin
                up_found = 1'b1;
                up_floor = floor_t'(i);
            end
        end
    end

    // Scan from the bottom so the closest floor below wins
    always_comb begin
        down_found = 1'b0;
        down_floor = current_floor;
        for (int i = 0; i < `ELEV_NUM_FLOORS; i++) begin
            if (pending[i] && (i < int'(current_floor))) begin
                down_found = 1'b1;
                down_floor = floor_t'(i);
            end
        end
    end

    ////////////////////////////////////////
    // Target choice
    ////////////////////////////////////////

    // Keep going the last way, else turn, else stay put
    always_comb begin
        target_next = target_floor;
        if (load_target) begin
            if (elevator_direction == DIR_UP) begin
                if (up_found) begin
                    target_next = up_floor;
                end else if (down_found) begin
                    target_next = down_floor;
                end else begin
                    target_next = current_floor;
                end
            end else begin
                if (down_found) begin
                    target_next = down_floor;
                end else if (up_found) begin
                    target_next = up_floor;
                end else begin
                    target_next = current_floor;
                end
            end
        end
    end

    // Serving until the car reaches the floor just chosen
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state        <= SCHED_IDLE;
            target_floor <= '0;
        end else begin
            target_floor <= target_next;
            state        <= (target_next != current_floor) ? SCHED_SERVING : SCHED_IDLE;
        end
    end

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    // A moving car keeps the target it was sent to
    property p_target_held_moving;
        @(posedge clock) disable iff (!reset_n)
            elevator_moving |=> $stable(target_floor);
    endproperty

    a_target_held_moving : assert property (p_target_held_moving)
        else $error("target floor changed while car moving");

endmodule

`default_nettype wire

// ==== hw/motion_control.sv ====
// Start, direction and door commands

`default_nettype none
`timescale 1ns/1ps

module motion_control (
    input  wire                       clock,
    input  wire                       reset_n,
    input  wire elevator_pkg::floor_t target_floor,
    input  wire elevator_pkg::floor_t current_floor,
    input  wire                       elevator_moving,
    input  wire                       power_switch,
    input  wire                       emergency_btn,
    input  wire                       door_open_btn,
    input  wire                       door_close_btn,
    output logic                      activate_elevator,
    output elevator_pkg::dir_e        direction_selector,
    output logic                      door_open_allowed,
    output logic                      door_close_allowed
);
    import elevator_pkg::*;

    logic start_ok;
    logic doors_ok;

    // Standing, powered, no emergency and somewhere to go
    assign start_ok = power_switch && !emergency_btn && !elevator_moving
                      && (target_floor != current_floor);

    // Door buttons only matter in a standing, powered car
    assign doors_ok = power_switch && !elevator_moving;

    ////////////////////////////////////////
    // Output registers
    ////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            activate_elevator  <= 1'b0;
            direction_selector <= DIR_DOWN;
            door_open_allowed  <= 1'b0;
            door_close_allowed <= 1'b0;
        end else begin
            activate_elevator <= start_ok;
            // Direction only moves when a start is issued
            if (start_ok) begin
                direction_selector <= (target_floor > current_floor) ? DIR_UP : DIR_DOWN;
            end
            door_open_allowed  <= doors_ok && door_open_btn;
            door_close_allowed <= doors_ok && door_close_btn;
        end
    end

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    // Emergency blocks the start command on the next cycle
    property p_no_start_in_emergency;
        @(posedge clock) disable iff (!reset_n)
            emergency_btn |=> !activate_elevator;
    endproperty

    a_no_start_in_emergency : assert property (p_no_start_in_emergency)
        else $error("start issued right after emergency");

endmodule

`default_nettype wire

// ==== hw/request_latch.sv ====
// Call and panel request lamps

`default_nettype none
`timescale 1ns/1ps

module request_latch (
    input  wire                        clock,
    input  wire                        reset_n,
    input  wire elevator_pkg::floor_mask_t floor_call_buttons,
    input  wire elevator_pkg::floor_mask_t panel_buttons,
    input  wire                        power_switch,
    input  wire                        emergency_btn,
    input  wire elevator_pkg::floor_t  current_floor,
    input  wire                        elevator_moving,
    output elevator_pkg::floor_mask_t  call_button_lights,
    output elevator_pkg::floor_mask_t  panel_button_lights
);
    import elevator_pkg::*;

    logic        accept_presses;
    floor_mask_t here_mask;
    floor_mask_t arrive_clear;
    floor_mask_t call_set;
    floor_mask_t panel_set;
    floor_mask_t call_next;
    floor_mask_t panel_next;

    ////////////////////////////////////////
    // Press qualification
    ////////////////////////////////////////

    // Buttons only count with power on and no emergency
    assign accept_presses = power_switch && !emergency_btn;

    // One-hot marker of the floor the car is at
    assign here_mask = floor_mask_t'(1) << current_floor;

    // A press for the floor the car is already at is dropped
    assign call_set  = accept_presses ? (floor_call_buttons & ~here_mask) : '0;
    assign panel_set = accept_presses ? (panel_buttons & ~here_mask) : '0;

    // Standing car serves both lamps of its floor
    assign arrive_clear = elevator_moving ? '0 : here_mask;

    ////////////////////////////////////////
    // Lamp registers
    ////////////////////////////////////////

    // Every press of the cycle is merged in one step
    assign call_next  = (call_button_lights | call_set) & ~arrive_clear;
    assign panel_next = (panel_button_lights | panel_set) & ~arrive_clear;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            call_button_lights  <= '0;
            panel_button_lights <= '0;
        end else begin
            call_button_lights  <= call_next;
            panel_button_lights <= panel_next;
        end
    end

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    // Stopped car never shows a lit lamp for the floor it stood at
    property p_no_lamp_at_stop;
        @(posedge clock) disable iff (!reset_n)
            !elevator_moving |=>
                ((call_button_lights | panel_button_lights) & $past(here_mask)) == '0;
    endproperty

    a_no_lamp_at_stop : assert property (p_no_lamp_at_stop)
        else $error("lamp lit at floor where car is stopped");

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+hw
hw/elevator_pkg.sv
hw/request_latch.sv
hw/floor_scheduler.sv
hw/motion_control.sv
hw/floor_logic_top.sv
tb/floor_logic_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the floor request controller testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f project.f \
    --top-module floor_logic_tb \
    --Mdir obj_dir

output=$(./obj_dir/Vfloor_logic_tb)
echo "$output"

if echo "$output" | grep -q "Verification passed"; then
    exit 0
else
    exit 1
fi

// ==== tb/floor_logic_tb.sv ====
// Floor request controller testbench

`default_nettype none
`timescale 1ns/1ps

`include "elevator_params.svh"

module floor_logic_tb;
    import elevator_pkg::*;

    localparam int SETTLE_CYCLES = 4;
    localparam int WAIT_LIMIT    = 1000;
    localparam int RANDOM_ROUNDS = 24;

    typedef struct packed {
        floor_mask_t call_press;
        floor_mask_t panel_press;
        floor_t      floor_now;
        logic        moving;
        logic        dir;
        logic        power;
        logic        emergency;
        logic        door_open;
        logic        door_close;
        floor_mask_t exp_call;
        floor_mask_t exp_panel;
        floor_t      exp_target;
        logic        exp_act;
        logic        exp_dir;
        logic        exp_open;
        logic        exp_close;
    } row_t;

    logic        clock;
    logic        reset_n;
    floor_mask_t floor_call_buttons;
    floor_mask_t panel_buttons;
    logic        door_open_btn;
    logic        door_close_btn;
    logic        emergency_btn;
    logic        power_switch;
    floor_t      current_floor;
    logic        elevator_moving;
    dir_e        elevator_direction;
    floor_mask_t call_button_lights;
    floor_mask_t panel_button_lights;
    floor_t      elevator_floor_selector;
    dir_e        direction_selector;
    logic        activate_elevator;
    logic        door_open_allowed;
    logic        door_close_allowed;

    row_t        rows[$];
    int          pass_count;
    int          fail_count;
    integer      seed;

    floor_logic_top dut0 (
        .clock                   (clock),
        .reset_n                 (reset_n),
        .floor_call_buttons      (floor_call_buttons),
        .panel_buttons           (panel_buttons),
        .door_open_btn           (door_open_btn),
        .door_close_btn          (door_close_btn),
        .emergency_btn           (emergency_btn),
        .power_switch            (power_switch),
        .current_floor           (current_floor),
        .elevator_moving         (elevator_moving),
        .elevator_direction      (elevator_direction),
        .call_button_lights      (call_button_lights),
        .panel_button_lights     (panel_button_lights),
        .elevator_floor_selector (elevator_floor_selector),
        .direction_selector      (direction_selector),
        .activate_elevator       (activate_elevator),
        .door_open_allowed       (door_open_allowed),
        .door_close_allowed      (door_close_allowed)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // Watchdog on the whole run
    initial begin
        #200000;
        $display("Simulation timed out before the test sequence ended");
        $display("Verification failed");
        $finish;
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    task automatic wait_edges(input int n);
        int count;
        count = 0;
        while (count < n) begin
            if (count >= WAIT_LIMIT) begin
                $display("Wait for %0d clock edges ran past its limit", n);
                fail_count++;
                break;
            end
            @(posedge clock);
            count++;
        end
    endtask

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp, inout bit row_ok);
        assert (got == exp) begin
            pass_count++;
        end else begin
            $display("MISMATCH at %0t: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
            fail_count++;
            row_ok = 1'b0;
        end
    endtask

    task automatic add_row(input floor_mask_t cp, input floor_mask_t pp, input int fl,
                           input logic mv, input logic dr, input logic pw, input logic em,
                           input logic dop, input logic dcl, input floor_mask_t ec,
                           input floor_mask_t ep, input int et, input logic ea,
                           input logic ed, input logic eo, input logic ecl);
        row_t r;
        r = '{cp, pp, floor_t'(fl), mv, dr, pw, em, dop, dcl,
              ec, ep, floor_t'(et), ea, ed, eo, ecl};
        rows.push_back(r);
    endtask

    // Rows run in order and lamps and target carry over from row to row
    task automatic build_table();
        //       call   panel  flr mv dr pw em op cl | call   panel  tgt act dir op cl
        add_row(11'h000, 11'h000, 0, 0, 0, 1, 0, 0, 0, 11'h000, 11'h000, 0, 0, 0, 0, 0);
        add_row(11'h020, 11'h000, 3, 0, 0, 0, 0, 0, 0, 11'h000, 11'h000, 3, 0, 0, 0, 0);
        add_row(11'h000, 11'h040, 3, 0, 0, 1, 1, 0, 0, 11'h000, 11'h000, 3, 0, 0, 0, 0);
        add_row(11'h008, 11'h008, 3, 0, 0, 1, 0, 0, 0, 11'h000, 11'h000, 3, 0, 0, 0, 0);
        add_row(11'h002, 11'h040, 3, 0, 1, 1, 0, 0, 0, 11'h002, 11'h040, 6, 1, 1, 0, 0);
        add_row(11'h000, 11'h000, 6, 0, 1, 1, 0, 0, 0, 11'h002, 11'h000, 1, 1, 0, 0, 0);
        add_row(11'h000, 11'h000, 1, 0, 0, 1, 0, 0, 0, 11'h000, 11'h000, 1, 0, 0, 0, 0);
        add_row(11'h002, 11'h040, 3, 0, 0, 1, 0, 0, 0, 11'h002, 11'h040, 1, 1, 0, 0, 0);
        add_row(11'h200, 11'h000, 3, 1, 0, 1, 0, 1, 0, 11'h202, 11'h040, 1, 0, 0, 0, 0);
        add_row(11'h000, 11'h100, 2, 1, 0, 1, 0, 0, 1, 11'h202, 11'h140, 1, 0, 0, 0, 0);
        add_row(11'h000, 11'h000, 1, 0, 0, 1, 0, 0, 0, 11'h200, 11'h140, 6, 1, 1, 0, 0);
        add_row(11'h000, 11'h000, 1, 0, 0, 1, 0, 1, 0, 11'h200, 11'h140, 6, 1, 1, 1, 0);
        add_row(11'h000, 11'h000, 1, 0, 0, 1, 1, 0, 1, 11'h200, 11'h140, 6, 0, 1, 0, 1);
        add_row(11'h000, 11'h000, 1, 0, 0, 0, 0, 0, 0, 11'h200, 11'h140, 6, 0, 1, 0, 0);
    endtask

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial begin
        row_t        r;
        bit          row_ok;
        floor_mask_t model_call;
        floor_mask_t model_panel;
        floor_mask_t here;
        floor_mask_t call_rand;
        floor_mask_t panel_rand;
        floor_t      floor_rand;

        reset_n            = 1'b0;
        floor_call_buttons = '0;
        panel_buttons      = '0;
        door_open_btn      = 1'b0;
        door_close_btn     = 1'b0;
        emergency_btn      = 1'b0;
        power_switch       = 1'b0;
        current_floor      = '0;
        elevator_moving    = 1'b0;
        elevator_direction = DIR_DOWN;
        pass_count         = 0;
        fail_count         = 0;
        seed               = 32'h8a3;

        build_table();
        wait_edges(10);
        reset_n <= 1'b1;

        // Outputs still hold their reset values before the next edge
        row_ok = 1'b1;
        @(negedge clock);
        compare_field("reset call lamps", 32'(call_button_lights), 32'(0), row_ok);
        compare_field("reset panel lamps", 32'(panel_button_lights), 32'(0), row_ok);
        compare_field("reset target", 32'(elevator_floor_selector), 32'(0), row_ok);
        compare_field("reset activate", 32'(activate_elevator), 32'(0), row_ok);
        compare_field("reset direction", 32'(direction_selector), 32'(DIR_DOWN), row_ok);
        compare_field("reset door open", 32'(door_open_allowed), 32'(0), row_ok);
        compare_field("reset door close", 32'(door_close_allowed), 32'(0), row_ok);
        $display("Reset values: %s", row_ok ? "ok" : "FAILED");

        for (int i = 0; i < rows.size(); i++) begin
            r      = rows[i];
            row_ok = 1'b1;
            @(posedge clock);
            floor_call_buttons <= r.call_press;
            panel_buttons      <= r.panel_press;
            current_floor      <= r.floor_now;
            elevator_moving    <= r.moving;
            elevator_direction <= dir_e'(r.dir);
            power_switch       <= r.power;
            emergency_btn      <= r.emergency;
            door_open_btn      <= r.door_open;
            door_close_btn     <= r.door_close;
            // Presses last one cycle only
            @(posedge clock);
            floor_call_buttons <= '0;
            panel_buttons      <= '0;
            wait_edges(SETTLE_CYCLES);
            @(negedge clock);
            compare_field("call lamps", 32'(call_button_lights), 32'(r.exp_call), row_ok);
            compare_field("panel lamps", 32'(panel_button_lights), 32'(r.exp_panel), row_ok);
            compare_field("target", 32'(elevator_floor_selector), 32'(r.exp_target), row_ok);
            compare_field("activate", 32'(activate_elevator), 32'(r.exp_act), row_ok);
            compare_field("direction", 32'(direction_selector), 32'(r.exp_dir), row_ok);
            compare_field("door open", 32'(door_open_allowed), 32'(r.exp_open), row_ok);
            compare_field("door close", 32'(door_close_allowed), 32'(r.exp_close), row_ok);
            $display("Row %0d: %s", i, row_ok ? "ok" : "FAILED");
        end

        // Random presses on a standing, powered car
        model_call  = 11'h200;
        model_panel = 11'h140;
        row_ok      = 1'b1;
        @(posedge clock);
        power_switch    <= 1'b1;
        emergency_btn   <= 1'b0;
        elevator_moving <= 1'b0;
        for (int k = 0; k < RANDOM_ROUNDS; k++) begin
            call_rand  = floor_mask_t'($random(seed));
            panel_rand = floor_mask_t'($random(seed));
            floor_rand = floor_t'(32'($unsigned($random(seed))) % `ELEV_NUM_FLOORS);
            @(posedge clock);
            floor_call_buttons <= call_rand;
            panel_buttons      <= panel_rand;
            current_floor      <= floor_rand;
            @(posedge clock);
            floor_call_buttons <= '0;
            panel_buttons      <= '0;
            here        = floor_mask_t'(1) << floor_rand;
            model_call  = (model_call | (call_rand & ~here)) & ~here;
            model_panel = (model_panel | (panel_rand & ~here)) & ~here;
            @(negedge clock);
            compare_field("random call lamps", 32'(call_button_lights), 32'(model_call), row_ok);
            compare_field("random panel lamps", 32'(panel_button_lights), 32'(model_panel),
                          row_ok);
        end
        $display("Random lamp test: %s", row_ok ? "ok" : "FAILED");

        $display("Checks passed: %0d, checks failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
